// File: hw/fifo_cntr_pkg.sv
`default_nettype none

/* sizing for the synchronous FIFO controller. The depth need not be a power of two.
   The thresholds are fixed here, and AFULL_VAL and AEMPTY_VAL must lie inside 0..FIFO_DEPTH */

package fifo_cntr_pkg;

   // --------------------
   // depth and widths
   // --------------------
   localparam int unsigned FIFO_DEPTH = 12;   // memory entries

   // address covers 0 .. FIFO_DEPTH-1
   localparam int unsigned ADDR_W = $clog2(FIFO_DEPTH);

   // level must hold FIFO_DEPTH itself, hence the +1
   localparam int unsigned LVL_W = $clog2(FIFO_DEPTH + 1);

   // --------------------
   // flag thresholds
   // --------------------
   // afull when level >= AFULL_VAL
   localparam int unsigned AFULL_VAL = 10;

   // aempty when level <= AEMPTY_VAL
   localparam int unsigned AEMPTY_VAL = 2;

   // --------------------
   // types
   // --------------------
   // memory address, wraps at FIFO_DEPTH
   typedef logic [ADDR_W-1:0] addr_t;

   // occupancy, 0 .. FIFO_DEPTH
   typedef logic [LVL_W-1:0] lvl_t;

endpackage : fifo_cntr_pkg

`default_nettype wire

// File: hw/ring_addr_counter.sv
`timescale 1ns/1ps
`default_nettype none

/* wrapping memory address. It steps once per advance_i and goes from FIFO_DEPTH-1 back to 0.
   The new address shows after the accepting edge */

module ring_addr_counter (
   input  logic                  pos_clk,     // fifo clock
   input  logic                  aresetn,     // async reset, active low
   input  logic                  advance_i,   // accepted request
   output fifo_cntr_pkg::addr_t  addr_o       // current memory address
);

   import fifo_cntr_pkg::*;

   // last valid address before the wrap
   localparam addr_t ADDR_LAST = addr_t'(FIFO_DEPTH - 1);

   // --------------------
   // address register
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         addr_o <= '0;
      end else if (advance_i) begin
         if (addr_o == ADDR_LAST) begin
            addr_o <= '0;               // non power of two wrap
         end else begin
            addr_o <= addr_o + 1'b1;
         end
      end
   end

   // --------------------
   // checks
   // --------------------
   // addresses above the depth would hit memory that is not there
   property p_addr_in_range;
      @(posedge pos_clk) disable iff (!aresetn)
         addr_o < addr_t'(FIFO_DEPTH);
   endproperty
   a_addr_in_range : assert property (p_addr_in_range)
      else $error("address %0d beyond depth", addr_o);

endmodule : ring_addr_counter

`default_nettype wire

// File: hw/fifo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

/* request gating and status pulses. full_i and empty_i are the registered flags.
   A refused request is dropped. It only raises overflow or underflow for one cycle */

module fifo_ctrl (
   input  logic pos_clk,       // fifo clock
   input  logic aresetn,       // async reset, active low
   input  logic wr_en_i,       // write request, level
   input  logic rd_en_i,       // read request, level
   input  logic full_i,        // registered full flag
   input  logic empty_i,       // registered empty flag
   output logic wr_ok_o,       // accepted write, same cycle
   output logic rd_ok_o,       // accepted read, same cycle
   output logic wack_o,        // write ack, one cycle late
   output logic dvld_o,        // read data valid, one cycle late
   output logic overflow_o,    // write refused while full
   output logic underflow_o    // read refused while empty
);

   // --------------------
   // request gating
   // --------------------
   // purely combinational, goes straight to the memory enables
   assign wr_ok_o = wr_en_i & ~full_i;
   assign rd_ok_o = rd_en_i & ~empty_i;

   // --------------------
   // status pulses
   // --------------------
   // each pulse follows its request cycle by one edge
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o      <= 1'b0;
         dvld_o      <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         wack_o      <= wr_ok_o;              // write landed in memory
         dvld_o      <= rd_ok_o;              // read data valid now
         overflow_o  <= wr_en_i & full_i;     // write dropped
         underflow_o <= rd_en_i & empty_i;    // read dropped
      end
   end

   // --------------------
   // checks
   // --------------------
   // the memory must never see a write into a full FIFO
   property p_no_wr_when_full;
      @(posedge pos_clk) disable iff (!aresetn)
         full_i |-> !wr_ok_o;
   endproperty
   a_no_wr_when_full : assert property (p_no_wr_when_full)
      else $error("memory write enabled while full");

   // and never a read from an empty one
   property p_no_rd_when_empty;
      @(posedge pos_clk) disable iff (!aresetn)
         empty_i |-> !rd_ok_o;
   endproperty
   a_no_rd_when_empty : assert property (p_no_rd_when_empty)
      else $error("memory read enabled while empty");

   // a write cycle is either acked or flagged, never both
   property p_wack_excl_ovf;
      @(posedge pos_clk) disable iff (!aresetn)
         !(wack_o && overflow_o);
   endproperty
   a_wack_excl_ovf : assert property (p_wack_excl_ovf)
      else $error("wack and overflow high together");

endmodule : fifo_ctrl

`default_nettype wire

// File: hw/fifo_level_flags.sv
`timescale 1ns/1ps
`default_nettype none

/* occupancy counter and registered status flags. The flags come from the next level,
   so they change on the same edge as level_o. The inputs must already be gated */

module fifo_level_flags (
   input  logic                 pos_clk,    // fifo clock
   input  logic                 aresetn,    // async reset, active low
   input  logic                 wr_ok_i,    // accepted write
   input  logic                 rd_ok_i,    // accepted read
   output fifo_cntr_pkg::lvl_t  level_o,    // entries in memory
   output logic                 full_o,
   output logic                 afull_o,
   output logic                 empty_o,
   output logic                 aempty_o
);

   import fifo_cntr_pkg::*;

   // thresholds cast once to the level width
   localparam lvl_t LVL_FULL   = lvl_t'(FIFO_DEPTH);
   localparam lvl_t LVL_AFULL  = lvl_t'(AFULL_VAL);
   localparam lvl_t LVL_AEMPTY = lvl_t'(AEMPTY_VAL);

   lvl_t lvl_nxt;        // level after this edge
   logic full_nxt;
   logic afull_nxt;
   logic empty_nxt;
   logic aempty_nxt;

   // --------------------
   // next level
   // --------------------
   // gating upstream keeps this inside 0..FIFO_DEPTH
   always_comb begin
      unique case ({wr_ok_i, rd_ok_i})
         2'b10:   lvl_nxt = level_o + 1'b1;   // write only
         2'b01:   lvl_nxt = level_o - 1'b1;   // read only
         default: lvl_nxt = level_o;          // idle, or write and read together
      endcase
   end

   // --------------------
   // next flags
   // --------------------
   // all four are decoded from lvl_nxt and not from the registered level.
   // Otherwise the flags would trail the count by a cycle
   always_comb begin
      full_nxt   = (lvl_nxt == LVL_FULL);
      empty_nxt  = (lvl_nxt == '0);
      afull_nxt  = (lvl_nxt >= LVL_AFULL);    // inclusive
      aempty_nxt = (lvl_nxt <= LVL_AEMPTY);   // inclusive
   end

   // --------------------
   // level register
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_o <= '0;
      end else begin
         level_o <= lvl_nxt;
      end
   end

   // --------------------
   // flag registers
   // --------------------
   // reset state is an empty fifo
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_o   <= 1'b0;
         afull_o  <= 1'b0;
         empty_o  <= 1'b1;
         aempty_o <= 1'b1;
      end else begin
         full_o   <= full_nxt;
         afull_o  <= afull_nxt;
         empty_o  <= empty_nxt;
         aempty_o <= aempty_nxt;
      end
   end

   // --------------------
   // checks
   // --------------------
   // an ungated write at full would push the count past the depth
   property p_level_in_range;
      @(posedge pos_clk) disable iff (!aresetn)
         level_o <= LVL_FULL;
   endproperty
   a_level_in_range : assert property (p_level_in_range)
      else $error("level %0d beyond depth", level_o);

   // flags are mutually exclusive for any nonzero depth
   property p_full_excl_empty;
      @(posedge pos_clk) disable iff (!aresetn)
         !(full_o && empty_o);
   endproperty
   a_full_excl_empty : assert property (p_full_excl_empty)
      else $error("full and empty high together");

endmodule : fifo_level_flags

`default_nettype wire

// File: hw/fifo_sync_cntr_top.sv
`timescale 1ns/1ps
`default_nettype none

/* synchronous FIFO controller for an external memory, single clock.
   mem_we_o and mem_re_o are combinational from the requests and the registered flags */

module fifo_sync_cntr_top (
   input  logic                  pos_clk,       // fifo clock
   input  logic                  aresetn,       // async reset, active low
   input  logic                  wr_en_i,       // write request
   input  logic                  rd_en_i,       // read request
   output logic                  full_o,
   output logic                  afull_o,
   output logic                  empty_o,
   output logic                  aempty_o,
   output fifo_cntr_pkg::lvl_t   level_o,       // occupancy
   output logic                  wack_o,
   output logic                  dvld_o,
   output logic                  overflow_o,
   output logic                  underflow_o,
   output fifo_cntr_pkg::addr_t  mem_waddr_o,   // memory write address
   output fifo_cntr_pkg::addr_t  mem_raddr_o,   // memory read address
   output logic                  mem_we_o,      // memory write enable
   output logic                  mem_re_o       // memory read enable
);

   logic wr_ok;    // gated write
   logic rd_ok;    // gated read
   logic full;     // fed back to the gating
   logic empty;

   // --------------------
   // exports
   // --------------------
   assign mem_we_o = wr_ok;
   assign mem_re_o = rd_ok;
   assign full_o   = full;
   assign empty_o  = empty;

   // --------------------
   // request gating
   // --------------------
   fifo_ctrl u_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en_i),
      .rd_en_i     (rd_en_i),
      .full_i      (full),
      .empty_i     (empty),
      .wr_ok_o     (wr_ok),
      .rd_ok_o     (rd_ok),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   // --------------------
   // address counters
   // --------------------
   ring_addr_counter u_waddr (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .advance_i (wr_ok),
      .addr_o    (mem_waddr_o)
   );

   ring_addr_counter u_raddr (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .advance_i (rd_ok),
      .addr_o    (mem_raddr_o)
   );

   // level and flags, one edge after the accept
   fifo_level_flags u_lvl (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .wr_ok_i  (wr_ok),
      .rd_ok_i  (rd_ok),
      .level_o  (level_o),
      .full_o   (full),
      .afull_o  (afull_o),
      .empty_o  (empty),
      .aempty_o (aempty_o)
   );

endmodule : fifo_sync_cntr_top

`default_nettype wire

// File: sim/fifo_ref_model.svh
/* reference model of the FIFO controller, included inside the testbench module
   after the package import. It steps once per clock from the driven requests */

`ifndef FIFO_REF_MODEL_SVH
`define FIFO_REF_MODEL_SVH

// --------------------
// model state
// --------------------
// all values as they should look after the last edge
lvl_t  m_level;
logic  m_full;
logic  m_afull;
logic  m_empty;
logic  m_aempty;
addr_t m_waddr;      // next memory write slot
addr_t m_raddr;      // next memory read slot
logic  m_wack;
logic  m_dvld;
logic  m_ovf;
logic  m_udf;

// empty FIFO, both pointers home, no pulses
task model_reset;
   m_level  = '0;
   m_full   = 1'b0;
   m_afull  = 1'b0;
   m_empty  = 1'b1;
   m_aempty = 1'b1;
   m_waddr  = '0;
   m_raddr  = '0;
   m_wack   = 1'b0;
   m_dvld   = 1'b0;
   m_ovf    = 1'b0;
   m_udf    = 1'b0;
endtask

// write reaches memory unless full
function logic model_we(input logic wr);
   return wr && !m_full;
endfunction

// read reaches memory unless empty
function logic model_re(input logic rd);
   return rd && !m_empty;
endfunction

// one step along the ring, depth need not be a power of two
function addr_t addr_after(input addr_t a);
   return addr_t'((int'(a) + 1) % int'(FIFO_DEPTH));
endfunction

// --------------------
// one clock edge
// --------------------
task model_step(input logic wr, input logic rd);
   logic we;
   logic re;
   int   lvl;
   we = model_we(wr);
   re = model_re(rd);
   m_wack = we;
   m_dvld = re;
   m_ovf  = wr && m_full;          // refused write
   m_udf  = rd && m_empty;         // refused read
   if (we) m_waddr = addr_after(m_waddr);
   if (re) m_raddr = addr_after(m_raddr);
   lvl = int'(m_level) + int'(we) - int'(re);   // write and read together cancel
   m_level  = lvl_t'(lvl);
   m_full   = (lvl == int'(FIFO_DEPTH));
   m_empty  = (lvl == 0);
   m_afull  = (lvl >= int'(AFULL_VAL));
   m_aempty = (lvl <= int'(AEMPTY_VAL));
endtask

`endif

// File: sim/tb_fifo_sync_cntr.sv
`timescale 1ns/1ps
`default_nettype none

/* random testbench for fifo_sync_cntr_top, fixed seed, three traffic phases.
   Inputs change 10 ns after each rising edge. Expected values come from the model */

module tb_fifo_sync_cntr;

   import fifo_cntr_pkg::*;

   localparam int RST_CYCLES = 4;
   localparam int RST_WAIT   = 20;     // cycles allowed until reset release
   localparam int WR_CYCLES  = 300;
   localparam int RD_CYCLES  = 300;
   localparam int BAL_CYCLES = 400;
   localparam int PH_WR      = 0;      // write-heavy
   localparam int PH_RD      = 1;      // read-heavy
   localparam int PH_BAL     = 2;

   logic  pos_clk;
   logic  aresetn;
   logic  wr_en;
   logic  rd_en;
   logic  full;
   logic  afull;
   logic  empty;
   logic  aempty;
   lvl_t  level;
   logic  wack;
   logic  dvld;
   logic  overflow;
   logic  underflow;
   addr_t mem_waddr;
   addr_t mem_raddr;
   logic  mem_we;
   logic  mem_re;

   integer seed;
   int     err_cnt;     // value mismatches
   int     to_cnt;      // loops that ran out
   logic   saw_full;
   logic   saw_empty;

   `include "fifo_ref_model.svh"

   fifo_sync_cntr_top uut (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en),
      .rd_en_i     (rd_en),
      .full_o      (full),
      .afull_o     (afull),
      .empty_o     (empty),
      .aempty_o    (aempty),
      .level_o     (level),
      .wack_o      (wack),
      .dvld_o      (dvld),
      .overflow_o  (overflow),
      .underflow_o (underflow),
      .mem_waddr_o (mem_waddr),
      .mem_raddr_o (mem_raddr),
      .mem_we_o    (mem_we),
      .mem_re_o    (mem_re)
   );

   always #50 pos_clk = ~pos_clk;   // 100 ns period

   // reset low for four edges, released at the drive point
   initial begin
      aresetn = 1'b0;
      repeat (RST_CYCLES) @(posedge pos_clk);
      #10 aresetn = 1'b1;
   end

   // --------------------
   // compare tasks
   // --------------------
   task check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
         err_cnt++;
      end
   endtask

   task check_lvl(input string name, input lvl_t exp, input lvl_t act);
      if (act !== exp) begin
         $display("ERROR %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
         err_cnt++;
      end
   endtask

   task check_addr(input string name, input addr_t exp, input addr_t act);
      if (act !== exp) begin
         $display("ERROR %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
         err_cnt++;
      end
   endtask

   // every registered output against the model
   task check_outputs;
      check_lvl("level_o", m_level, level);
      check_bit("full_o", m_full, full);
      check_bit("afull_o", m_afull, afull);
      check_bit("empty_o", m_empty, empty);
      check_bit("aempty_o", m_aempty, aempty);
      check_addr("mem_waddr_o", m_waddr, mem_waddr);
      check_addr("mem_raddr_o", m_raddr, mem_raddr);
      check_bit("wack_o", m_wack, wack);
      check_bit("dvld_o", m_dvld, dvld);
      check_bit("overflow_o", m_ovf, overflow);
      check_bit("underflow_o", m_udf, underflow);
   endtask

   // --------------------
   // one clock of traffic
   // --------------------
   // entered at edge + 10 ns, left at the next edge + 10 ns
   task run_cycle(input logic wr, input logic rd);
      wr_en = wr;
      rd_en = rd;
      #30;                                       // enables settled well before the edge
      check_bit("mem_we_o", model_we(wr), mem_we);
      check_bit("mem_re_o", model_re(rd), mem_re);
      model_step(wr, rd);
      @(posedge pos_clk);
      #10;
      check_outputs();
      if (full === 1'b1) saw_full = 1'b1;
      if (empty === 1'b1) saw_empty = 1'b1;
   endtask

   // bounded run of random traffic with a given bias
   task run_phase(input int kind, input int n_cycles);
      logic [31:0] r;
      logic        wr;
      logic        rd;
      saw_full  = 1'b0;
      saw_empty = 1'b0;
      for (int i = 0; i < n_cycles; i++) begin
         r = $random(seed);
         if (kind == PH_WR) begin
            wr = (r[2:0] != 3'd0);    // 7 of 8
            rd = (r[4:3] == 2'd0);    // 1 of 4
         end else if (kind == PH_RD) begin
            wr = (r[4:3] == 2'd0);
            rd = (r[2:0] != 3'd0);
         end else begin
            wr = r[0];
            rd = r[1];
         end
         run_cycle(wr, rd);
      end
      if (kind == PH_WR && !saw_full) begin
         $display("full flag was never reached in %0d write-heavy cycles", n_cycles);
         to_cnt++;
      end
      if (kind == PH_RD && !saw_empty) begin
         $display("empty flag was never reached in %0d read-heavy cycles", n_cycles);
         to_cnt++;
      end
   endtask

   // reset values while aresetn is still low, then poll for the release
   task wait_reset;
      int cnt;
      cnt = 0;
      @(posedge pos_clk);
      #10;
      check_outputs();                 // registers held by aresetn
      while (aresetn !== 1'b1 && cnt < RST_WAIT) begin
         @(posedge pos_clk);
         cnt++;
      end
      if (aresetn !== 1'b1) begin
         $display("reset was never released within %0d cycles", RST_WAIT);
         to_cnt++;
      end else begin
         #10;
         check_outputs();
      end
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      pos_clk   = 1'b0;
      wr_en     = 1'b0;
      rd_en     = 1'b0;
      seed      = 32'hce72;
      err_cnt   = 0;
      to_cnt    = 0;
      saw_full  = 1'b0;
      saw_empty = 1'b0;
      model_reset();
      wait_reset();
      if (to_cnt == 0) begin
         run_phase(PH_WR, WR_CYCLES);
         run_phase(PH_RD, RD_CYCLES);
         run_phase(PH_BAL, BAL_CYCLES);
      end
      $display("errors: %0d mismatches, %0d timeouts", err_cnt, to_cnt);
      if (err_cnt == 0 && to_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule : tb_fifo_sync_cntr

`default_nettype wire

// File: src.f
+incdir+sim
hw/fifo_cntr_pkg.sv
hw/ring_addr_counter.sv
hw/fifo_ctrl.sv
hw/fifo_level_flags.sv
hw/fifo_sync_cntr_top.sv
sim/tb_fifo_sync_cntr.sv

// File: Bender.yml
package:
  name: fifo_sync_cntr

sources:
  - files:
      - hw/fifo_cntr_pkg.sv
      - hw/ring_addr_counter.sv
      - hw/fifo_ctrl.sv
      - hw/fifo_level_flags.sv
      - hw/fifo_sync_cntr_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_fifo_sync_cntr.sv
